/* hw/ex_params.svh */
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// data path and register file
`define EX_XLEN 32
`define EX_REG_ADDR_W 5
`define EX_SHAMT_W 5

// fetch redirect
`define EX_BR_ADDR_W 12
`define EX_LINK_OFFSET 4

// bank field sits above the sram word address
`define EX_SRAM_ADDR_W 13
`define EX_SRAM_TYPE_LSB 13
`define EX_SRAM_TYPE_W 2

`endif

/* hw/ex_pkg.sv */
`include "ex_params.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] xlen_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EX_BR_ADDR_W-1:0] br_addr_t;
    typedef logic [`EX_SRAM_ADDR_W-1:0] sram_addr_t;

    // integer, upper-immediate, jump and branch ops
    typedef enum logic [4:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_auipc,
        alu_jal,
        alu_jalr,
        alu_beq,
        alu_bne,
        alu_blt,
        alu_bge,
        alu_bltu,
        alu_bgeu
    } alu_op_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lh,
        mem_lw,
        mem_lbu,
        mem_lhu,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_t;

    // encoding matches the bank field of an address
    typedef enum logic [`EX_SRAM_TYPE_W-1:0] {
        sram_iram = 2'd0,
        sram_oram = 2'd1,
        sram_wram = 2'd2,
        sram_none = 2'd3
    } sram_sel_t;

endpackage

/* hw/ex_alu.sv */
`include "ex_params.svh"

module ex_alu
    import ex_pkg::*;
(
    input  alu_op_t op,
    input  xlen_t   src1,
    input  xlen_t   src2,
    input  xlen_t   pc,
    output xlen_t   result
);

    logic [`EX_SHAMT_W-1:0] shamt;
    xlen_t                  link;

    assign shamt = src2[`EX_SHAMT_W-1:0];
    assign link  = pc + xlen_t'(`EX_LINK_OFFSET);

    always_comb begin
        case (op)
            alu_add: begin
                result = src1 + src2;
            end
            alu_sub: begin
                result = src1 - src2;
            end
            alu_slt: begin
                result = xlen_t'($signed(src1) < $signed(src2));
            end
            alu_sltu: begin
                result = xlen_t'(src1 < src2);
            end
            alu_xor: begin
                result = src1 ^ src2;
            end
            alu_or: begin
                result = src1 | src2;
            end
            alu_and: begin
                result = src1 & src2;
            end
            alu_sll: begin
                result = src1 << shamt;
            end
            alu_srl: begin
                result = src1 >> shamt;
            end
            alu_sra: begin
                // sign fill
                result = xlen_t'($signed(src1) >>> shamt);
            end
            alu_lui: begin
                result = src2;
            end
            alu_auipc: begin
                result = pc + src2;
            end
            alu_jal, alu_jalr: begin
                result = link;
            end
            // branches and nop write nothing useful
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* hw/ex_branch.sv */
`include "ex_params.svh"

module ex_branch
    import ex_pkg::*;
(
    input  alu_op_t  op,
    input  xlen_t    src1,
    input  xlen_t    src2,
    input  xlen_t    imm,
    input  xlen_t    pc,
    output logic     taken,
    output br_addr_t target
);

    xlen_t target_sum;
    logic  eq;
    logic  lt_s;
    logic  lt_u;

    assign eq   = (src1 == src2);
    assign lt_s = ($signed(src1) < $signed(src2));
    assign lt_u = (src1 < src2);

    always_comb begin
        case (op)
            alu_beq:  taken = eq;
            alu_bne:  taken = !eq;
            alu_blt:  taken = lt_s;
            alu_bge:  taken = !lt_s;
            alu_bltu: taken = lt_u;
            alu_bgeu: taken = !lt_u;
            alu_jal, alu_jalr: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // jal carries its offset in src2, branches in imm
    always_comb begin
        case (op)
            alu_jal: begin
                target_sum = pc + src2;
            end
            alu_jalr: begin
                target_sum = src1 + src2;
            end
            default: begin
                target_sum = pc + imm;
            end
        endcase
    end

    assign target = target_sum[`EX_BR_ADDR_W-1:0];

endmodule

/* hw/ex_mem_addr.sv */
`include "ex_params.svh"

module ex_mem_addr
    import ex_pkg::*;
(
    input  mem_op_t    mem_op,
    input  xlen_t      src1,
    input  xlen_t      src2,
    input  xlen_t      imm,
    output sram_sel_t  sram_sel,
    output sram_addr_t sram_addr
);

    xlen_t                      addr_sum;
    logic [`EX_SRAM_TYPE_W-1:0] bank;

    always_comb begin
        case (mem_op)
            mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu: begin
                addr_sum = src1 + src2;
            end
            mem_sb, mem_sh, mem_sw: begin
                addr_sum = src1 + imm;
            end
            default: begin
                addr_sum = '0;
            end
        endcase
    end

    assign bank = addr_sum[`EX_SRAM_TYPE_LSB +: `EX_SRAM_TYPE_W];

    always_comb begin
        if (mem_op == mem_none || bank == sram_none) begin
            sram_sel  = sram_none;
            sram_addr = '0;
        end else begin
            sram_sel  = sram_sel_t'(bank);
            sram_addr = addr_sum[`EX_SRAM_ADDR_W-1:0];
        end
    end

endmodule

/* hw/ex_stage_reg.sv */
module ex_stage_reg
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  alu_op_t    in_op,
    input  mem_op_t    in_mem_op,
    input  logic       in_wb_valid,
    input  reg_addr_t  in_wb_addr,
    input  xlen_t      result,
    input  logic       taken,
    input  br_addr_t   target,
    input  sram_sel_t  sram_sel,
    input  sram_addr_t sram_addr,
    input  xlen_t      store_data,
    input  logic       out_ready,
    output logic       in_ready,
    output logic       out_valid,
    output logic       out_wb_valid,
    output reg_addr_t  out_wb_addr,
    output xlen_t      out_result,
    output mem_op_t    out_mem_op,
    output sram_sel_t  out_sram_sel,
    output sram_addr_t out_sram_addr,
    output xlen_t      out_store_data,
    output logic       redirect_valid,
    output br_addr_t   redirect_addr
);

    logic is_branch;
    logic accept;
    logic load;

    // room when empty or the held item leaves this cycle
    assign in_ready  = out_ready || !out_valid;
    assign is_branch = (in_op inside {alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu});

    // instruction behind a redirect is consumed and dropped
    assign accept = in_valid && in_ready && !redirect_valid;
    assign load   = accept && !is_branch;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid      <= 1'b0;
            out_wb_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            out_valid      <= load || (out_valid && !out_ready);
            redirect_valid <= accept && taken;
            if (load) begin
                out_wb_valid <= in_wb_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_wb_addr    <= in_wb_addr;
            out_result     <= result;
            out_mem_op     <= in_mem_op;
            out_sram_sel   <= sram_sel;
            out_sram_addr  <= sram_addr;
            out_store_data <= store_data;
        end
        if (accept && taken) begin
            redirect_addr <= target;
        end
    end

    // fetch never sees back to back redirect pulses
    redirect_single: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |=> !redirect_valid);

    // memory stage must see a frozen item while it stalls
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_wb_valid)
            && $stable(out_wb_addr) && $stable(out_result) && $stable(out_mem_op)
            && $stable(out_sram_sel) && $stable(out_sram_addr)
            && $stable(out_store_data));

endmodule

/* hw/ex_stage.sv */
module ex_stage
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  alu_op_t    in_op,
    input  mem_op_t    in_mem_op,
    input  xlen_t      in_src1,
    input  xlen_t      in_src2,
    input  xlen_t      in_imm,
    input  xlen_t      in_pc,
    input  logic       in_wb_valid,
    input  reg_addr_t  in_wb_addr,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       out_wb_valid,
    output reg_addr_t  out_wb_addr,
    output xlen_t      out_result,
    output mem_op_t    out_mem_op,
    output sram_sel_t  out_sram_sel,
    output sram_addr_t out_sram_addr,
    output xlen_t      out_store_data,
    output logic       redirect_valid,
    output br_addr_t   redirect_addr
);

    xlen_t      alu_result;
    logic       br_taken;
    br_addr_t   br_target;
    sram_sel_t  mem_sel;
    sram_addr_t mem_addr;

    ex_alu u_alu (
        .op     (in_op),
        .src1   (in_src1),
        .src2   (in_src2),
        .pc     (in_pc),
        .result (alu_result)
    );

    ex_branch u_branch (
        .op     (in_op),
        .src1   (in_src1),
        .src2   (in_src2),
        .imm    (in_imm),
        .pc     (in_pc),
        .taken  (br_taken),
        .target (br_target)
    );

    ex_mem_addr u_mem_addr (
        .mem_op    (in_mem_op),
        .src1      (in_src1),
        .src2      (in_src2),
        .imm       (in_imm),
        .sram_sel  (mem_sel),
        .sram_addr (mem_addr)
    );

    // store data is rs2
    ex_stage_reg u_stage_reg (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_mem_op      (in_mem_op),
        .in_wb_valid    (in_wb_valid),
        .in_wb_addr     (in_wb_addr),
        .result         (alu_result),
        .taken          (br_taken),
        .target         (br_target),
        .sram_sel       (mem_sel),
        .sram_addr      (mem_addr),
        .store_data     (in_src2),
        .out_ready      (out_ready),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_wb_valid   (out_wb_valid),
        .out_wb_addr    (out_wb_addr),
        .out_result     (out_result),
        .out_mem_op     (out_mem_op),
        .out_sram_sel   (out_sram_sel),
        .out_sram_addr  (out_sram_addr),
        .out_store_data (out_store_data),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr)
    );

endmodule

/* test/tb_ex_stage.sv */
`include "ex_params.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int N_ARITH         = 200;
    localparam int N_BRANCH        = 150;
    localparam int N_JUMP          = 60;
    localparam int N_MEM           = 120;
    localparam int N_MIXED         = 300;
    localparam int N_TOTAL         = N_ARITH + N_BRANCH + N_JUMP + N_MEM + N_MIXED;
    localparam int WATCHDOG_CYCLES = N_TOTAL * 20 + RESET_CYCLES;

    typedef struct packed {
        xlen_t      result;
        logic       taken;
        br_addr_t   target;
        sram_sel_t  sel;
        sram_addr_t addr;
        logic       wb_valid;
        reg_addr_t  wb_addr;
        mem_op_t    mem_op;
        xlen_t      store_data;
    } expect_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    alu_op_t    in_op;
    mem_op_t    in_mem_op;
    xlen_t      in_src1;
    xlen_t      in_src2;
    xlen_t      in_imm;
    xlen_t      in_pc;
    logic       in_wb_valid;
    reg_addr_t  in_wb_addr;
    logic       out_valid;
    logic       out_ready;
    logic       out_wb_valid;
    reg_addr_t  out_wb_addr;
    xlen_t      out_result;
    mem_op_t    out_mem_op;
    sram_sel_t  out_sram_sel;
    sram_addr_t out_sram_addr;
    xlen_t      out_store_data;
    logic       redirect_valid;
    br_addr_t   redirect_addr;

    integer   seed = 92034;
    integer   ready_seed = 92035;
    logic     stall_mode = 1'b0;
    int       value_errors = 0;
    int       other_errors = 0;
    int       transfer_count = 0;
    int       flush_count = 0;
    logic     redirect_due = 1'b0;
    br_addr_t redirect_exp;
    expect_t  exp_q[$];

    ex_stage DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // expected values straight from the instruction rules
    function automatic expect_t ex_ref(alu_op_t op, mem_op_t mem_op, xlen_t src1,
                                       xlen_t src2, xlen_t imm, xlen_t pc);
        expect_t     e;
        int unsigned sh;
        xlen_t       sum;
        xlen_t       addr_sum;
        logic        lt_s;
        logic [1:0]  bank;
        e    = '0;
        sh   = src2 % 32;
        sum  = pc + imm;
        // signs differ means the negative one is smaller
        lt_s = (src1[`EX_XLEN-1] != src2[`EX_XLEN-1]) ? src1[`EX_XLEN-1] : (src1 < src2);
        case (op)
            alu_add:   e.result = src1 + src2;
            alu_sub:   e.result = src1 - src2;
            alu_slt:   e.result = lt_s ? 1 : 0;
            alu_sltu:  e.result = (src1 < src2) ? 1 : 0;
            alu_xor:   e.result = src1 ^ src2;
            alu_or:    e.result = src1 | src2;
            alu_and:   e.result = src1 & src2;
            alu_sll:   e.result = src1 << sh;
            alu_srl:   e.result = src1 >> sh;
            alu_sra: begin
                e.result = src1 >> sh;
                if (src1[`EX_XLEN-1]) begin
                    e.result = e.result | ~({`EX_XLEN{1'b1}} >> sh);
                end
            end
            alu_lui:   e.result = src2;
            alu_auipc: e.result = pc + src2;
            alu_jal: begin
                e.result = pc + `EX_LINK_OFFSET;
                e.taken  = 1'b1;
                sum      = pc + src2;
            end
            alu_jalr: begin
                e.result = pc + `EX_LINK_OFFSET;
                e.taken  = 1'b1;
                sum      = src1 + src2;
            end
            alu_beq:   e.taken = (src1 == src2);
            alu_bne:   e.taken = (src1 != src2);
            alu_blt:   e.taken = lt_s;
            alu_bge:   e.taken = !lt_s;
            alu_bltu:  e.taken = (src1 < src2);
            alu_bgeu:  e.taken = !(src1 < src2);
            default:   e.result = '0;
        endcase
        e.target = sum[`EX_BR_ADDR_W-1:0];
        // loads offset by src2, stores by imm
        if (mem_op inside {mem_sb, mem_sh, mem_sw}) begin
            addr_sum = src1 + imm;
        end else begin
            addr_sum = src1 + src2;
        end
        bank = addr_sum[`EX_SRAM_TYPE_LSB +: 2];
        if (mem_op == mem_none || bank == 2'd3) begin
            e.sel  = sram_none;
            e.addr = '0;
        end else begin
            e.sel  = sram_sel_t'(bank);
            e.addr = addr_sum[`EX_SRAM_ADDR_W-1:0];
        end
        return e;
    endfunction

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_word(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_br(string name, br_addr_t got, br_addr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_sel(string name, sram_sel_t got, sram_sel_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_addr(string name, sram_addr_t got, sram_addr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_mem_op(string name, mem_op_t got, mem_op_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // mid-cycle view of what the next rising edge will do
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (!reset) begin
            if (redirect_due) begin
                check_flag("redirect_valid", redirect_valid, 1'b1);
                check_br("redirect_addr", redirect_addr, redirect_exp);
            end else begin
                check_flag("redirect_valid", redirect_valid, 1'b0);
            end
            // ready whenever the register is empty or draining
            check_flag("in_ready", in_ready, out_ready || !out_valid);
            if (out_valid && exp_q.size() == 0) begin
                $display("out_valid is high with no instruction outstanding");
                other_errors++;
            end else if (!out_valid && exp_q.size() != 0) begin
                $display("out_valid is low one cycle after an instruction was accepted");
                other_errors++;
            end else if (out_valid && out_ready) begin
                e = exp_q.pop_front();
                transfer_count++;
                check_flag("out_wb_valid", out_wb_valid, e.wb_valid);
                check_reg("out_wb_addr", out_wb_addr, e.wb_addr);
                check_word("out_result", out_result, e.result);
                check_mem_op("out_mem_op", out_mem_op, e.mem_op);
                check_sel("out_sram_sel", out_sram_sel, e.sel);
                check_addr("out_sram_addr", out_sram_addr, e.addr);
                check_word("out_store_data", out_store_data, e.store_data);
            end
            redirect_due = 1'b0;
            if (in_valid && in_ready && redirect_valid) begin
                flush_count++;
            end else if (in_valid && in_ready) begin
                e            = ex_ref(in_op, in_mem_op, in_src1, in_src2, in_imm, in_pc);
                e.wb_valid   = in_wb_valid;
                e.wb_addr    = in_wb_addr;
                e.mem_op     = in_mem_op;
                e.store_data = in_src2;
                redirect_due = e.taken;
                redirect_exp = e.target;
                if (!(in_op inside {alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu})) begin
                    exp_q.push_back(e);
                end
            end
        end
    end

    // back-pressure from the memory stage
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = stall_mode ? ($random(ready_seed) % 3 != 0) : 1'b1;
        end
    end

    task automatic send_instr(alu_op_t op, mem_op_t mop, xlen_t a, xlen_t b, xlen_t imm);
        logic done;
        if (rand_below(8) == 0) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        in_valid    = 1'b1;
        in_op       = op;
        in_mem_op   = mop;
        in_src1     = a;
        in_src2     = b;
        in_imm      = imm;
        in_pc       = $random(seed);
        in_pc[1:0]  = 2'b00;
        in_wb_valid = rand_below(4) != 0;
        in_wb_addr  = reg_addr_t'(rand_below(32));
        done        = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // kind 0 arithmetic, 1 branch, 2 jump, 3 load or store
    task automatic send_kind(int unsigned kind);
        xlen_t   a;
        xlen_t   b;
        xlen_t   imm;
        xlen_t   off;
        mem_op_t mop;
        a   = $random(seed);
        b   = $random(seed);
        imm = $random(seed);
        case (kind)
            0: send_instr(alu_op_t'(1 + rand_below(12)), mem_none, a, b, imm);
            1: begin
                if (rand_below(4) == 0) begin
                    b = a;
                end
                send_instr(alu_op_t'(15 + rand_below(6)), mem_none, a, b, imm);
            end
            2: send_instr(rand_below(2) != 0 ? alu_jalr : alu_jal, mem_none, a, b, imm);
            default: begin
                mop = mem_op_t'(1 + rand_below(8));
                a[`EX_SRAM_TYPE_LSB +: 2]  = 2'(rand_below(4));
                // keep the offset from carrying into the bank field
                a[`EX_SRAM_TYPE_LSB-1] = 1'b0;
                off = rand_below(2048);
                if (mop inside {mem_sb, mem_sh, mem_sw}) begin
                    imm = off;
                end else begin
                    b = off;
                end
                send_instr(alu_add, mop, a, b, imm);
            end
        endcase
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_op       = alu_nop;
        in_mem_op   = mem_none;
        in_src1     = '0;
        in_src2     = '0;
        in_imm      = '0;
        in_pc       = '0;
        in_wb_valid = 1'b0;
        in_wb_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        repeat (N_ARITH) send_kind(0);
        repeat (N_BRANCH) send_kind(1);
        repeat (N_JUMP) send_kind(2);
        repeat (N_MEM) send_kind(3);
        stall_mode = 1'b1;
        repeat (N_MIXED) send_kind(rand_below(4));
        stall_mode = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d other (%0d transfers, %0d flushed)",
                 value_errors, other_errors, transfer_count, flush_count);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the instruction sequence completed");
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_mem_addr.sv
hw/ex_stage_reg.sv
hw/ex_stage.sv
test/tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ex_stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_ex_stage -f flist.f \
    -Mdir obj_dir -o sim_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ex_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
